//--- list.f
hw/dbgCfgPkg.sv
hw/dbgRegDecode.sv
hw/dbgCfgRegs.sv
hw/dbgReadMux.sv
hw/dbgCoreSync.sv
hw/dbgCfgTop.sv
verif/dbgCfgTb_assert.sv
verif/dbgCfgTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dbgCfgTb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verif/dbgCfgTb.sv
/* Testbench for the debug and configuration block: clocks, bus stimulus,
   register map reference model, read compare, watchdog and summary */
module dbgCfgTb;

  import dbgCfgPkg::*;

  localparam int PHYS_LOG      = 7;
  localparam int PRF_BYTE_LOG  = 2;
  localparam int RMT_LOG       = 5;
  localparam int CLK_PERIOD    = 20;
  localparam int PLANNED_TRANS = 220;
  localparam int WATCHDOG_TIME = PLANNED_TRANS * 4 * CLK_PERIOD + 50 * CLK_PERIOD;

  logic ioClk, coreClk, reset;
  regAddrT regAddr;
  regDataT regWrData, regRdData;
  logic regWrEn;
  pcT currentInstPC;
  regDataT debugPRFRdData;
  logic [PHYS_LOG-1:0] debugAMTRdData;
  logic pipeDrained, reconfigDone, resetFetch, stallFetch, reconfigureCore;
  logic resetSync, resetFetchSync, stallFetchSync, reconfigureCoreSync;
  laneMaskT fetchLane, dispatchLane, issueLane, execLane;
  commitMaskT commitLane;
  rfPartT rfPart;
  lsqPartT lsqPart;
  ibuffPartT ibuffPart;
  logic [PHYS_LOG+PRF_BYTE_LOG-1:0] debugPRFAddr;
  regDataT debugPRFWrData;
  logic debugPRFWrEn;
  logic [RMT_LOG-1:0] debugAMTAddr;

  // register map model
  laneMaskT mFetch, mDispatch, mIssue, mExec;
  commitMaskT mCommit;
  rfPartT mRfPart;
  lsqPartT mLsq;
  ibuffPartT mIbuff;
  regDataT mScratch, mPrfLo, mPrfData;
  logic [PHYS_LOG+PRF_BYTE_LOG-9:0] mPrfHi;
  logic [RMT_LOG-1:0] mAmt;
  logic mPd, mRd;

  integer seed = 32'h5d25;
  logic reqValid, chkValid;
  regDataT reqExp, chkExp;
  regAddrT reqAddr, chkAddr;
  int errCount = 0;
  int checkCount = 0;
  int testStartErr = 0;
  int pulseCount = 0;
  logic [PHYS_LOG+PRF_BYTE_LOG-1:0] seenAddr;
  regDataT seenData;
  regAddrT mapped [19] = '{ADDR_ID, ADDR_FETCH, ADDR_DISPATCH, ADDR_ISSUE, ADDR_EXEC,
    ADDR_COMMIT, ADDR_RFPART, ADDR_LSQPART, ADDR_STATUS, ADDR_SCRATCH, ADDR_PRF_LO,
    ADDR_PRF_HI, ADDR_PRF_DATA, ADDR_PC0, ADDR_PC1, ADDR_PC2, ADDR_PC3, ADDR_AMT,
    ADDR_AMT_DATA};
  regAddrT masks [8] = '{ADDR_FETCH, ADDR_DISPATCH, ADDR_ISSUE, ADDR_EXEC, ADDR_COMMIT,
    ADDR_RFPART, ADDR_LSQPART, ADDR_STATUS};

  dbgCfgTop #(.PHYS_LOG(PHYS_LOG), .PRF_BYTE_LOG(PRF_BYTE_LOG), .RMT_LOG(RMT_LOG))
  dbgCfgTop_inst
  (
    .ioClk(ioClk), .coreClk(coreClk), .reset(reset), .regAddr_i(regAddr),
    .regWrData_i(regWrData), .regWrEn_i(regWrEn), .regRdData_o(regRdData),
    .currentInstPC_i(currentInstPC), .debugPRFRdData_i(debugPRFRdData),
    .debugAMTRdData_i(debugAMTRdData), .pipeDrained_i(pipeDrained),
    .reconfigDone_i(reconfigDone), .resetFetch_i(resetFetch),
    .stallFetch_i(stallFetch), .reconfigureCore_i(reconfigureCore),
    .reset_sync_o(resetSync), .resetFetch_sync_o(resetFetchSync),
    .stallFetch_sync_o(stallFetchSync), .reconfigureCore_sync_o(reconfigureCoreSync),
    .fetchLane_o(fetchLane), .dispatchLane_o(dispatchLane), .issueLane_o(issueLane),
    .execLane_o(execLane), .commitLane_o(commitLane), .rfPart_o(rfPart),
    .lsqPart_o(lsqPart), .ibuffPart_o(ibuffPart), .debugPRFAddr_o(debugPRFAddr),
    .debugPRFWrData_o(debugPRFWrData), .debugPRFWrEn_o(debugPRFWrEn),
    .debugAMTAddr_o(debugAMTAddr)
  );

  initial
  begin
    ioClk = 1'b0;
    forever #(CLK_PERIOD / 2) ioClk = ~ioClk;
  end

  initial
  begin
    coreClk = 1'b0;
    #5;   // quarter period behind ioClk
    forever #(CLK_PERIOD / 2) coreClk = ~coreClk;
  end

  function automatic regDataT randByte();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[7:0];
  endfunction

  function automatic regDataT expectRead(input regAddrT a);
    case (a)
      ADDR_ID:       return CHIP_ID;
      ADDR_FETCH:    return regDataT'(mFetch);
      ADDR_DISPATCH: return regDataT'(mDispatch);
      ADDR_ISSUE:    return regDataT'(mIssue);
      ADDR_EXEC:     return regDataT'(mExec);
      ADDR_COMMIT:   return regDataT'(mCommit);
      ADDR_RFPART:   return mRfPart;
      ADDR_LSQPART:  return regDataT'(mLsq);
      ADDR_STATUS:   return {2'b00, mPd, mRd, mIbuff};
      ADDR_PRF_LO:   return mPrfLo;
      ADDR_PRF_HI:   return debugPRFRdData;   // core read data
      ADDR_PRF_DATA: return mPrfData;
      ADDR_PC0:      return currentInstPC[7:0];
      ADDR_PC1:      return currentInstPC[15:8];
      ADDR_PC2:      return currentInstPC[23:16];
      ADDR_PC3:      return currentInstPC[31:24];
      ADDR_AMT:      return regDataT'(mAmt);
      ADDR_AMT_DATA: return regDataT'(debugAMTRdData);
      default:       return mScratch;
    endcase
  endfunction

  function automatic regDataT coreMask(input regAddrT a);
    case (a)
      ADDR_FETCH:    return regDataT'(fetchLane);
      ADDR_DISPATCH: return regDataT'(dispatchLane);
      ADDR_ISSUE:    return regDataT'(issueLane);
      ADDR_EXEC:     return regDataT'(execLane);
      ADDR_COMMIT:   return regDataT'(commitLane);
      ADDR_RFPART:   return rfPart;
      ADDR_LSQPART:  return regDataT'(lsqPart);
      default:       return regDataT'(ibuffPart);
    endcase
  endfunction

  task automatic modelWrite(input regAddrT a, input regDataT d);
    case (a)
      ADDR_FETCH:    mFetch = d[5:0];
      ADDR_DISPATCH: mDispatch = d[5:0];
      ADDR_ISSUE:    mIssue = d[5:0];
      ADDR_EXEC:     mExec = d[5:0];
      ADDR_COMMIT:   mCommit = d[3:0];
      ADDR_RFPART:   mRfPart = d;
      ADDR_LSQPART:  mLsq = d[1:0];
      ADDR_STATUS:   mIbuff = d[3:0];
      ADDR_PRF_LO:   mPrfLo = d;
      ADDR_PRF_HI:   mPrfHi = d[PHYS_LOG+PRF_BYTE_LOG-9:0];
      ADDR_PRF_DATA: mPrfData = d;
      ADDR_AMT:      mAmt = d[RMT_LOG-1:0];
      default:       mScratch = d;   // read-only and unmapped
    endcase
  endtask

  task automatic busWrite(input regAddrT a, input regDataT d);
    @(negedge ioClk);
    regAddr = a;
    regWrData = d;
    regWrEn = 1'b1;
    reqValid = 1'b0;
    modelWrite(a, d);
  endtask

  task automatic busRead(input regAddrT a);
    @(negedge ioClk);
    regAddr = a;
    regWrEn = 1'b0;
    reqValid = 1'b1;
    reqAddr = a;
    reqExp = expectRead(a);
    if (a == ADDR_STATUS)
    begin
      mPd = 1'b0;   // read clears both flags
      mRd = 1'b0;
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge ioClk);
      regAddr = ADDR_ID;
      regWrEn = 1'b0;
      reqValid = 1'b0;
    end
  endtask

  task automatic checkValue(input string name, input regDataT got, input regDataT exp);
    checkCount++;
    assert (got === exp)
    else
    begin
      errCount++;
      $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic endTest(input string name);
    idle(2);
    #1;
    $display("test %s done, %0d errors", name, errCount - testStartErr);
    testStartErr = errCount;
  endtask

  // read compare, one edge after the address
  always @(posedge ioClk)
  begin
    chkValid <= reqValid;
    chkExp   <= reqExp;
    chkAddr  <= reqAddr;
  end

  always @(negedge ioClk)
  begin
    if (chkValid)
    begin
      checkCount++;
      assert (regRdData === chkExp)
      else
      begin
        errCount++;
        $display("ERROR t=%0t regRdData_o addr 0x%0h got 0x%0h expected 0x%0h",
                 $time, chkAddr, regRdData, chkExp);
      end
    end
  end

  always @(negedge coreClk)
  begin
    if (!reset && debugPRFWrEn)
    begin
      pulseCount++;
      seenAddr = debugPRFAddr;
      seenData = debugPRFWrData;
    end
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("timeout: the tests did not finish in the expected time");
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    regDataT d;
    reset = 1'b1;
    regAddr = ADDR_ID;
    regWrData = '0;
    regWrEn = 1'b0;
    currentInstPC = '0;
    debugPRFRdData = '0;
    debugAMTRdData = '0;
    pipeDrained = 1'b0;
    reconfigDone = 1'b0;
    resetFetch = 1'b0;
    stallFetch = 1'b0;
    reconfigureCore = 1'b0;
    reqValid = 1'b0;
    reqExp = '0;
    reqAddr = '0;
    mFetch = RST_FETCH;
    mDispatch = RST_DISPATCH;
    mIssue = RST_ISSUE;
    mExec = RST_EXEC;
    mCommit = RST_COMMIT;
    mRfPart = RST_RFPART;
    mLsq = RST_LSQPART;
    mIbuff = RST_IBUFF;
    mScratch = RST_SCRATCH;
    mPrfLo = '0;
    mPrfHi = '0;
    mPrfData = '0;
    mAmt = '0;
    mPd = 1'b0;
    mRd = 1'b0;
    repeat (4) @(posedge ioClk);
    @(negedge ioClk);
    checkValue("reset_sync_o", regDataT'(resetSync), 8'h01);
    reset = 1'b0;
    endTest("reset sync");

    foreach (mapped[i])
      busRead(mapped[i]);
    endTest("reset values");

    foreach (masks[i])
    begin
      repeat (3)
      begin
        busWrite(masks[i], randByte());
        busRead(masks[i]);
        idle(1);
        d = (masks[i] == ADDR_STATUS) ? regDataT'(mIbuff) : expectRead(masks[i]);
        checkValue("core mask", coreMask(masks[i]), d);
      end
    end
    endTest("mask write");

    busWrite(6'h06, randByte());
    busRead(6'h09);
    busWrite(6'h3F, randByte());
    busRead(6'h30);
    busRead(ADDR_SCRATCH);
    busWrite(ADDR_SCRATCH, randByte());
    busRead(6'h21);
    busWrite(ADDR_PC1, randByte());   // read-only, lands on scratch
    busRead(ADDR_SCRATCH);
    endTest("scratch");

    busWrite(ADDR_PRF_LO, randByte());
    busWrite(ADDR_PRF_HI, randByte());
    idle(2);
    checkValue("debugPRFWrEn_o idle", regDataT'(pulseCount), 8'h00);
    pulseCount = 0;
    busWrite(ADDR_PRF_DATA, randByte());
    busWrite(ADDR_AMT, randByte());
    idle(3);
    checkValue("debugPRFWrEn_o pulses", regDataT'(pulseCount), 8'h01);
    checkValue("debugPRFAddr_o low", seenAddr[7:0], mPrfLo);
    checkValue("debugPRFAddr_o high", regDataT'(seenAddr[PHYS_LOG+PRF_BYTE_LOG-1:8]),
               regDataT'(mPrfHi));
    checkValue("debugPRFWrData_o", seenData, mPrfData);
    checkValue("debugAMTAddr_o", regDataT'(debugAMTAddr), regDataT'(mAmt));
    @(negedge ioClk);
    currentInstPC = {randByte(), randByte(), randByte(), randByte()};
    debugPRFRdData = randByte();
    d = randByte();
    debugAMTRdData = d[PHYS_LOG-1:0];
    idle(2);
    foreach (mapped[i])
      if (mapped[i] >= ADDR_PRF_LO)
        busRead(mapped[i]);
    endTest("register file window");

    @(negedge ioClk);
    pipeDrained = 1'b1;
    mPd = 1'b1;
    idle(1);
    pipeDrained = 1'b0;
    busRead(ADDR_STATUS);
    busRead(ADDR_STATUS);
    idle(1);   // move off the status address before the pulses
    reconfigDone = 1'b1;
    pipeDrained = 1'b1;
    mRd = 1'b1;
    mPd = 1'b1;
    idle(1);
    reconfigDone = 1'b0;
    pipeDrained = 1'b0;
    idle(2);
    busRead(ADDR_STATUS);
    busRead(ADDR_STATUS);
    endTest("status flags");

    repeat (4)
    begin
      d = randByte();
      @(negedge ioClk);
      stallFetch = d[0];
      reconfigureCore = d[1];
      resetFetch = d[2];
      repeat (3) @(posedge coreClk);
      @(negedge ioClk);
      checkValue("stallFetch_sync_o", regDataT'(stallFetchSync), regDataT'(d[0]));
      checkValue("reconfigureCore_sync_o", regDataT'(reconfigureCoreSync), regDataT'(d[1]));
      checkValue("resetFetch_sync_o", regDataT'(resetFetchSync), regDataT'(d[2]));
    end
    endTest("control sync");

    $display("summary: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verif/dbgCfgTb_assert.sv
/* Concurrent checks on the debug block top level and their bind */
module dbgCfgTb_assert
(
  input logic                   ioClk,
  input logic                   coreClk,
  input logic                   reset,
  input dbgCfgPkg::regAddrT     regAddr_i,
  input dbgCfgPkg::regDataT     regRdData_i,
  input logic                   prfWrEn_i,
  input logic                   pipeFlag_i,
  input logic                   reconfigFlag_i
);

  import dbgCfgPkg::*;

  prfPulseSingle: assert property (@(posedge coreClk) disable iff (reset)
    prfWrEn_i |=> !prfWrEn_i)
    else $error("register file write strobe high for two coreClk cycles");

  readDataKnown: assert property (@(posedge ioClk) disable iff (reset)
    !$isunknown(regRdData_i))
    else $error("read data unknown after reset");

  statusClears: assert property (@(posedge ioClk) disable iff (reset)
    (regAddr_i == ADDR_STATUS) |=> (!pipeFlag_i && !reconfigFlag_i))
    else $error("status flags still set after a status read");

endmodule

bind dbgCfgTop dbgCfgTb_assert dbgCfgTb_assert_inst
(
  .ioClk(ioClk), .coreClk(coreClk), .reset(reset), .regAddr_i(regAddr_i),
  .regRdData_i(regRdData_o), .prfWrEn_i(debugPRFWrEn_o),
  .pipeFlag_i(dbgReadMux_inst.pipeDrainedFlag),
  .reconfigFlag_i(dbgReadMux_inst.reconfigDoneFlag)
);

//--- hw/dbgCfgTop.sv
/* Debug and configuration register block: decode, register state,
   read path and coreClk crossing */
module dbgCfgTop
#(
  parameter int PHYS_LOG     = 7,
  parameter int PRF_BYTE_LOG = 2,
  parameter int RMT_LOG      = 5
)
(
  input  logic                             ioClk,
  input  logic                             coreClk,
  input  logic                             reset,
  input  dbgCfgPkg::regAddrT               regAddr_i,
  input  dbgCfgPkg::regDataT               regWrData_i,
  input  logic                             regWrEn_i,
  output dbgCfgPkg::regDataT               regRdData_o,
  input  dbgCfgPkg::pcT                    currentInstPC_i,
  input  dbgCfgPkg::regDataT               debugPRFRdData_i,
  input  logic [PHYS_LOG-1:0]              debugAMTRdData_i,
  input  logic                             pipeDrained_i,
  input  logic                             reconfigDone_i,
  input  logic                             resetFetch_i,
  input  logic                             stallFetch_i,
  input  logic                             reconfigureCore_i,
  output logic                             reset_sync_o,
  output logic                             resetFetch_sync_o,
  output logic                             stallFetch_sync_o,
  output logic                             reconfigureCore_sync_o,
  output dbgCfgPkg::laneMaskT              fetchLane_o,
  output dbgCfgPkg::laneMaskT              dispatchLane_o,
  output dbgCfgPkg::laneMaskT              issueLane_o,
  output dbgCfgPkg::laneMaskT              execLane_o,
  output dbgCfgPkg::commitMaskT            commitLane_o,
  output dbgCfgPkg::rfPartT                rfPart_o,
  output dbgCfgPkg::lsqPartT               lsqPart_o,
  output dbgCfgPkg::ibuffPartT             ibuffPart_o,
  output logic [PHYS_LOG+PRF_BYTE_LOG-1:0] debugPRFAddr_o,
  output dbgCfgPkg::regDataT               debugPRFWrData_o,
  output logic                             debugPRFWrEn_o,
  output logic [RMT_LOG-1:0]               debugAMTAddr_o
);

  import dbgCfgPkg::*;

  regSelT                           regSel;
  logic                             wrStrobe;
  laneMaskT                         fetchLane, dispatchLane, issueLane, execLane;
  commitMaskT                       commitLane;
  rfPartT                           rfPart;
  lsqPartT                          lsqPart;
  ibuffPartT                        ibuffPart;
  regDataT                          scratch;
  logic [PHYS_LOG+PRF_BYTE_LOG-1:0] prfAddr;
  regDataT                          prfWrData;
  logic                             prfWrEn;
  logic [RMT_LOG-1:0]               amtAddr;

  dbgRegDecode dbgRegDecode_inst
  (
    .regAddr_i(regAddr_i), .regWrEn_i(regWrEn_i),
    .regSel_o(regSel), .wrStrobe_o(wrStrobe)
  );

  dbgCfgRegs #(.PHYS_LOG(PHYS_LOG), .PRF_BYTE_LOG(PRF_BYTE_LOG), .RMT_LOG(RMT_LOG))
  dbgCfgRegs_inst
  (
    .ioClk(ioClk), .reset(reset), .regSel_i(regSel), .wrStrobe_i(wrStrobe),
    .regWrData_i(regWrData_i),
    .fetchLane_o(fetchLane), .dispatchLane_o(dispatchLane),
    .issueLane_o(issueLane), .execLane_o(execLane), .commitLane_o(commitLane),
    .rfPart_o(rfPart), .lsqPart_o(lsqPart), .ibuffPart_o(ibuffPart),
    .scratch_o(scratch), .prfAddr_o(prfAddr), .prfWrData_o(prfWrData),
    .prfWrEn_o(prfWrEn), .amtAddr_o(amtAddr)
  );

  dbgReadMux #(.PHYS_LOG(PHYS_LOG), .PRF_BYTE_LOG(PRF_BYTE_LOG), .RMT_LOG(RMT_LOG))
  dbgReadMux_inst
  (
    .ioClk(ioClk), .reset(reset), .regSel_i(regSel),
    .fetchLane_i(fetchLane), .dispatchLane_i(dispatchLane),
    .issueLane_i(issueLane), .execLane_i(execLane), .commitLane_i(commitLane),
    .rfPart_i(rfPart), .lsqPart_i(lsqPart), .ibuffPart_i(ibuffPart),
    .scratch_i(scratch), .prfAddr_i(prfAddr), .prfWrData_i(prfWrData),
    .amtAddr_i(amtAddr), .currentInstPC_i(currentInstPC_i),
    .debugPRFRdData_i(debugPRFRdData_i), .debugAMTRdData_i(debugAMTRdData_i),
    .pipeDrained_i(pipeDrained_i), .reconfigDone_i(reconfigDone_i),
    .regRdData_o(regRdData_o)
  );

  dbgCoreSync #(.PHYS_LOG(PHYS_LOG), .PRF_BYTE_LOG(PRF_BYTE_LOG), .RMT_LOG(RMT_LOG))
  dbgCoreSync_inst
  (
    .coreClk(coreClk), .reset(reset), .resetFetch_i(resetFetch_i),
    .stallFetch_i(stallFetch_i), .reconfigureCore_i(reconfigureCore_i),
    .fetchLane_i(fetchLane), .dispatchLane_i(dispatchLane),
    .issueLane_i(issueLane), .execLane_i(execLane), .commitLane_i(commitLane),
    .rfPart_i(rfPart), .lsqPart_i(lsqPart), .ibuffPart_i(ibuffPart),
    .prfAddr_i(prfAddr), .prfWrData_i(prfWrData), .prfWrEn_i(prfWrEn),
    .amtAddr_i(amtAddr),
    .reset_sync_o(reset_sync_o), .resetFetch_sync_o(resetFetch_sync_o),
    .stallFetch_sync_o(stallFetch_sync_o),
    .reconfigureCore_sync_o(reconfigureCore_sync_o),
    .fetchLane_o(fetchLane_o), .dispatchLane_o(dispatchLane_o),
    .issueLane_o(issueLane_o), .execLane_o(execLane_o),
    .commitLane_o(commitLane_o), .rfPart_o(rfPart_o), .lsqPart_o(lsqPart_o),
    .ibuffPart_o(ibuffPart_o), .debugPRFAddr_o(debugPRFAddr_o),
    .debugPRFWrData_o(debugPRFWrData_o), .debugPRFWrEn_o(debugPRFWrEn_o),
    .debugAMTAddr_o(debugAMTAddr_o)
  );

endmodule

//--- hw/dbgCoreSync.sv
/* coreClk crossing: two-flop reset and control synchronizers,
   single-flop configuration and window registers */
module dbgCoreSync
#(
  parameter int PHYS_LOG     = 7,
  parameter int PRF_BYTE_LOG = 2,
  parameter int RMT_LOG      = 5
)
(
  input  logic                             coreClk,
  input  logic                             reset,
  input  logic                             resetFetch_i,
  input  logic                             stallFetch_i,
  input  logic                             reconfigureCore_i,
  input  dbgCfgPkg::laneMaskT              fetchLane_i,
  input  dbgCfgPkg::laneMaskT              dispatchLane_i,
  input  dbgCfgPkg::laneMaskT              issueLane_i,
  input  dbgCfgPkg::laneMaskT              execLane_i,
  input  dbgCfgPkg::commitMaskT            commitLane_i,
  input  dbgCfgPkg::rfPartT                rfPart_i,
  input  dbgCfgPkg::lsqPartT               lsqPart_i,
  input  dbgCfgPkg::ibuffPartT             ibuffPart_i,
  input  logic [PHYS_LOG+PRF_BYTE_LOG-1:0] prfAddr_i,
  input  dbgCfgPkg::regDataT               prfWrData_i,
  input  logic                             prfWrEn_i,
  input  logic [RMT_LOG-1:0]               amtAddr_i,
  output logic                             reset_sync_o,
  output logic                             resetFetch_sync_o,
  output logic                             stallFetch_sync_o,
  output logic                             reconfigureCore_sync_o,
  output dbgCfgPkg::laneMaskT              fetchLane_o,
  output dbgCfgPkg::laneMaskT              dispatchLane_o,
  output dbgCfgPkg::laneMaskT              issueLane_o,
  output dbgCfgPkg::laneMaskT              execLane_o,
  output dbgCfgPkg::commitMaskT            commitLane_o,
  output dbgCfgPkg::rfPartT                rfPart_o,
  output dbgCfgPkg::lsqPartT               lsqPart_o,
  output dbgCfgPkg::ibuffPartT             ibuffPart_o,
  output logic [PHYS_LOG+PRF_BYTE_LOG-1:0] debugPRFAddr_o,
  output dbgCfgPkg::regDataT               debugPRFWrData_o,
  output logic                             debugPRFWrEn_o,
  output logic [RMT_LOG-1:0]               debugAMTAddr_o
);

  logic [1:0] resetPipe;
  logic [1:0] resetFetchPipe;
  logic [1:0] stallPipe;
  logic [1:0] reconfigPipe;

  assign reset_sync_o           = resetPipe[1];
  assign resetFetch_sync_o      = resetFetchPipe[1];
  assign stallFetch_sync_o      = stallPipe[1];
  assign reconfigureCore_sync_o = reconfigPipe[1];

  // async assert, release two coreClk edges later
  always_ff @(posedge coreClk or posedge reset)
  begin
    if (reset)
    begin
      resetPipe      <= 2'b11;
      resetFetchPipe <= 2'b00;
      stallPipe      <= 2'b00;
      reconfigPipe   <= 2'b00;
      debugPRFWrEn_o <= 1'b0;
    end
    else
    begin
      resetPipe      <= {resetPipe[0], 1'b0};
      resetFetchPipe <= {resetFetchPipe[0], resetFetch_i};
      stallPipe      <= {stallPipe[0], stallFetch_i};
      reconfigPipe   <= {reconfigPipe[0], reconfigureCore_i};
      debugPRFWrEn_o <= prfWrEn_i;
    end
  end

  // quasi-static values, one flop is enough
  always_ff @(posedge coreClk)
  begin
    fetchLane_o      <= fetchLane_i;
    dispatchLane_o   <= dispatchLane_i;
    issueLane_o      <= issueLane_i;
    execLane_o       <= execLane_i;
    commitLane_o     <= commitLane_i;
    rfPart_o         <= rfPart_i;
    lsqPart_o        <= lsqPart_i;
    ibuffPart_o      <= ibuffPart_i;
    debugPRFAddr_o   <= prfAddr_i;
    debugPRFWrData_o <= prfWrData_i;
    debugAMTAddr_o   <= amtAddr_i;
  end

endmodule

//--- hw/dbgReadMux.sv
/* Core status sampling on ioClk, sticky status flags and the registered
   read data byte */
module dbgReadMux
#(
  parameter int PHYS_LOG     = 7,
  parameter int PRF_BYTE_LOG = 2,
  parameter int RMT_LOG      = 5
)
(
  input  logic                             ioClk,
  input  logic                             reset,
  input  dbgCfgPkg::regSelT                regSel_i,
  input  dbgCfgPkg::laneMaskT              fetchLane_i,
  input  dbgCfgPkg::laneMaskT              dispatchLane_i,
  input  dbgCfgPkg::laneMaskT              issueLane_i,
  input  dbgCfgPkg::laneMaskT              execLane_i,
  input  dbgCfgPkg::commitMaskT            commitLane_i,
  input  dbgCfgPkg::rfPartT                rfPart_i,
  input  dbgCfgPkg::lsqPartT               lsqPart_i,
  input  dbgCfgPkg::ibuffPartT             ibuffPart_i,
  input  dbgCfgPkg::regDataT               scratch_i,
  input  logic [PHYS_LOG+PRF_BYTE_LOG-1:0] prfAddr_i,
  input  dbgCfgPkg::regDataT               prfWrData_i,
  input  logic [RMT_LOG-1:0]               amtAddr_i,
  input  dbgCfgPkg::pcT                    currentInstPC_i,
  input  dbgCfgPkg::regDataT               debugPRFRdData_i,
  input  logic [PHYS_LOG-1:0]              debugAMTRdData_i,
  input  logic                             pipeDrained_i,
  input  logic                             reconfigDone_i,
  output dbgCfgPkg::regDataT               regRdData_o
);

  import dbgCfgPkg::*;

  pcT                  pcQ;
  regDataT             prfRdDataQ;
  logic [PHYS_LOG-1:0] amtRdDataQ;
  logic                pipeDrainedFlag;
  logic                reconfigDoneFlag;
  logic                statusRd;

  assign statusRd = (regSel_i == SEL_STATUS);

  // core side values, one ioClk sample
  always_ff @(posedge ioClk)
  begin
    pcQ        <= currentInstPC_i;
    prfRdDataQ <= debugPRFRdData_i;
    amtRdDataQ <= debugAMTRdData_i;
  end

  always_ff @(posedge ioClk or posedge reset)
  begin
    if (reset)
    begin
      pipeDrainedFlag  <= 1'b0;
      reconfigDoneFlag <= 1'b0;
    end
    else if (statusRd)
    begin
      pipeDrainedFlag  <= 1'b0;   // clear wins over a new pulse
      reconfigDoneFlag <= 1'b0;
    end
    else
    begin
      pipeDrainedFlag  <= pipeDrainedFlag | pipeDrained_i;
      reconfigDoneFlag <= reconfigDoneFlag | reconfigDone_i;
    end
  end

  always_ff @(posedge ioClk or posedge reset)
  begin
    if (reset)
      regRdData_o <= '0;
    else
    begin
      case (regSel_i)
        SEL_ID:       regRdData_o <= CHIP_ID;
        SEL_FETCH:    regRdData_o <= regDataT'(fetchLane_i);
        SEL_DISPATCH: regRdData_o <= regDataT'(dispatchLane_i);
        SEL_ISSUE:    regRdData_o <= regDataT'(issueLane_i);
        SEL_EXEC:     regRdData_o <= regDataT'(execLane_i);
        SEL_COMMIT:   regRdData_o <= regDataT'(commitLane_i);
        SEL_RFPART:   regRdData_o <= rfPart_i;
        SEL_LSQPART:  regRdData_o <= regDataT'(lsqPart_i);
        SEL_STATUS:   regRdData_o <= {2'b00, pipeDrainedFlag, reconfigDoneFlag, ibuffPart_i};
        SEL_PRF_LO:   regRdData_o <= prfAddr_i[7:0];
        SEL_PRF_HI:   regRdData_o <= prfRdDataQ;
        SEL_PRF_DATA: regRdData_o <= prfWrData_i;
        SEL_PC0:      regRdData_o <= pcQ[7:0];
        SEL_PC1:      regRdData_o <= pcQ[15:8];
        SEL_PC2:      regRdData_o <= pcQ[23:16];
        SEL_PC3:      regRdData_o <= pcQ[31:24];
        SEL_AMT:      regRdData_o <= regDataT'(amtAddr_i);
        SEL_AMT_DATA: regRdData_o <= regDataT'(amtRdDataQ);
        default:      regRdData_o <= scratch_i;   // scratch and unmapped
      endcase
    end
  end

endmodule

//--- hw/dbgCfgRegs.sv
/* Writable configuration state, register-file window address and
   the one-cycle register-file write strobe */
module dbgCfgRegs
#(
  parameter int PHYS_LOG     = 7,
  parameter int PRF_BYTE_LOG = 2,
  parameter int RMT_LOG      = 5
)
(
  input  logic                             ioClk,
  input  logic                             reset,
  input  dbgCfgPkg::regSelT                regSel_i,
  input  logic                             wrStrobe_i,
  input  dbgCfgPkg::regDataT               regWrData_i,
  output dbgCfgPkg::laneMaskT              fetchLane_o,
  output dbgCfgPkg::laneMaskT              dispatchLane_o,
  output dbgCfgPkg::laneMaskT              issueLane_o,
  output dbgCfgPkg::laneMaskT              execLane_o,
  output dbgCfgPkg::commitMaskT            commitLane_o,
  output dbgCfgPkg::rfPartT                rfPart_o,
  output dbgCfgPkg::lsqPartT               lsqPart_o,
  output dbgCfgPkg::ibuffPartT             ibuffPart_o,
  output dbgCfgPkg::regDataT               scratch_o,
  output logic [PHYS_LOG+PRF_BYTE_LOG-1:0] prfAddr_o,
  output dbgCfgPkg::regDataT               prfWrData_o,
  output logic                             prfWrEn_o,
  output logic [RMT_LOG-1:0]               amtAddr_o
);

  import dbgCfgPkg::*;

  localparam int PRF_ADDR_W = PHYS_LOG + PRF_BYTE_LOG;

  regDataT                 prfAddrLo;
  logic [PRF_ADDR_W-9:0]   prfAddrHi;

  assign prfAddr_o = {prfAddrHi, prfAddrLo};

  always_ff @(posedge ioClk or posedge reset)
  begin
    if (reset)
    begin
      fetchLane_o    <= RST_FETCH;
      dispatchLane_o <= RST_DISPATCH;
      issueLane_o    <= RST_ISSUE;
      execLane_o     <= RST_EXEC;
      commitLane_o   <= RST_COMMIT;
      rfPart_o       <= RST_RFPART;
      lsqPart_o      <= RST_LSQPART;
      ibuffPart_o    <= RST_IBUFF;
      scratch_o      <= RST_SCRATCH;
      prfAddrLo      <= '0;
      prfAddrHi      <= '0;
      prfWrData_o    <= '0;
      prfWrEn_o      <= 1'b0;
      amtAddr_o      <= '0;
    end
    else
    begin
      prfWrEn_o <= 1'b0;   // single cycle unless rewritten below
      if (wrStrobe_i)
      begin
        case (regSel_i)
          SEL_FETCH:    fetchLane_o    <= laneMaskT'(regWrData_i);
          SEL_DISPATCH: dispatchLane_o <= laneMaskT'(regWrData_i);
          SEL_ISSUE:    issueLane_o    <= laneMaskT'(regWrData_i);
          SEL_EXEC:     execLane_o     <= laneMaskT'(regWrData_i);
          SEL_COMMIT:   commitLane_o   <= commitMaskT'(regWrData_i);
          SEL_RFPART:   rfPart_o       <= regWrData_i;
          SEL_LSQPART:  lsqPart_o      <= lsqPartT'(regWrData_i);
          SEL_STATUS:   ibuffPart_o    <= ibuffPartT'(regWrData_i);
          SEL_PRF_LO:   prfAddrLo      <= regWrData_i;
          SEL_PRF_HI:   prfAddrHi      <= regWrData_i[PRF_ADDR_W-9:0];
          SEL_PRF_DATA:
          begin
            prfWrData_o <= regWrData_i;
            prfWrEn_o   <= 1'b1;
          end
          SEL_AMT:      amtAddr_o      <= regWrData_i[RMT_LOG-1:0];
          default:      scratch_o      <= regWrData_i;   // id, pc, amt data, unmapped
        endcase
      end
    end
  end

endmodule

//--- hw/dbgRegDecode.sv
/* Register address decoder: select and write strobe */
module dbgRegDecode
(
  input  dbgCfgPkg::regAddrT regAddr_i,
  input  logic               regWrEn_i,
  output dbgCfgPkg::regSelT  regSel_o,
  output logic               wrStrobe_o
);

  import dbgCfgPkg::*;

  always_comb
  begin
    case (regAddr_i)
      ADDR_ID:       regSel_o = SEL_ID;
      ADDR_FETCH:    regSel_o = SEL_FETCH;
      ADDR_DISPATCH: regSel_o = SEL_DISPATCH;
      ADDR_ISSUE:    regSel_o = SEL_ISSUE;
      ADDR_EXEC:     regSel_o = SEL_EXEC;
      ADDR_COMMIT:   regSel_o = SEL_COMMIT;
      ADDR_RFPART:   regSel_o = SEL_RFPART;
      ADDR_LSQPART:  regSel_o = SEL_LSQPART;
      ADDR_STATUS:   regSel_o = SEL_STATUS;
      ADDR_SCRATCH:  regSel_o = SEL_SCRATCH;
      ADDR_PRF_LO:   regSel_o = SEL_PRF_LO;
      ADDR_PRF_HI:   regSel_o = SEL_PRF_HI;
      ADDR_PRF_DATA: regSel_o = SEL_PRF_DATA;
      ADDR_PC0:      regSel_o = SEL_PC0;
      ADDR_PC1:      regSel_o = SEL_PC1;
      ADDR_PC2:      regSel_o = SEL_PC2;
      ADDR_PC3:      regSel_o = SEL_PC3;
      ADDR_AMT:      regSel_o = SEL_AMT;
      ADDR_AMT_DATA: regSel_o = SEL_AMT_DATA;
      default:       regSel_o = SEL_OTHER;   // unmapped, lands on scratch
    endcase
  end

  // an unknown enable never counts as a write
  assign wrStrobe_o = (regWrEn_i === 1'b1);

endmodule

//--- hw/dbgCfgPkg.sv
/* Register map, field widths, reset values and the register-select enum
   of the debug and configuration block */
package dbgCfgPkg;

  typedef logic [5:0]  regAddrT;
  typedef logic [7:0]  regDataT;
  typedef logic [31:0] pcT;
  typedef logic [5:0]  laneMaskT;      // fetch, dispatch, issue, execute
  typedef logic [3:0]  commitMaskT;
  typedef logic [7:0]  rfPartT;
  typedef logic [1:0]  lsqPartT;
  typedef logic [3:0]  ibuffPartT;

  typedef enum logic [4:0]
  {
    SEL_ID, SEL_FETCH, SEL_DISPATCH, SEL_ISSUE, SEL_EXEC, SEL_COMMIT,
    SEL_RFPART, SEL_LSQPART, SEL_STATUS, SEL_SCRATCH,
    SEL_PRF_LO, SEL_PRF_HI, SEL_PRF_DATA,
    SEL_PC0, SEL_PC1, SEL_PC2, SEL_PC3,
    SEL_AMT, SEL_AMT_DATA, SEL_OTHER
  } regSelT;

  localparam regDataT CHIP_ID = 8'hAC;

  localparam regAddrT ADDR_ID       = 6'h00;
  localparam regAddrT ADDR_FETCH    = 6'h01;
  localparam regAddrT ADDR_DISPATCH = 6'h02;
  localparam regAddrT ADDR_ISSUE    = 6'h03;
  localparam regAddrT ADDR_EXEC     = 6'h04;
  localparam regAddrT ADDR_COMMIT   = 6'h05;
  localparam regAddrT ADDR_RFPART   = 6'h07;
  localparam regAddrT ADDR_LSQPART  = 6'h08;
  localparam regAddrT ADDR_STATUS   = 6'h0A;   // also ibuff partitions
  localparam regAddrT ADDR_SCRATCH  = 6'h0D;
  localparam regAddrT ADDR_PRF_LO   = 6'h16;
  localparam regAddrT ADDR_PRF_HI   = 6'h17;
  localparam regAddrT ADDR_PRF_DATA = 6'h18;
  localparam regAddrT ADDR_PC0      = 6'h2A;
  localparam regAddrT ADDR_PC1      = 6'h2B;
  localparam regAddrT ADDR_PC2      = 6'h2C;
  localparam regAddrT ADDR_PC3      = 6'h2D;
  localparam regAddrT ADDR_AMT      = 6'h38;
  localparam regAddrT ADDR_AMT_DATA = 6'h39;

  localparam laneMaskT   RST_FETCH    = 6'h03;
  localparam laneMaskT   RST_DISPATCH = 6'h03;
  localparam laneMaskT   RST_ISSUE    = 6'h07;
  localparam laneMaskT   RST_EXEC     = 6'h07;
  localparam commitMaskT RST_COMMIT   = 4'h3;
  localparam rfPartT     RST_RFPART   = 8'hFF;
  localparam lsqPartT    RST_LSQPART  = 2'h3;
  localparam ibuffPartT  RST_IBUFF    = 4'hF;
  localparam regDataT    RST_SCRATCH  = 8'h15;

endpackage
